//--- build.f
rtl/mci_lite_pkg.sv
rtl/mci_lite_decode.sv
rtl/mci_lite_regs.sv
rtl/mci_lite_sram.sv
rtl/mci_lite_trace_buffer.sv
rtl/mci_lite_top.sv
sim/mci_lite_checker.sv
sim/mci_lite_tb.sv

//--- rtl/mci_lite_decode.sv
// Routes one SoC request to the control registers, trace buffer or MCU SRAM
// Purely combinational; clk and reset are only for bound assertions
// Addresses are compared on all 32 bits, so no aliasing above the map
// Privilege flags are valid only while soc_req.dv is high
`timescale 1ns/100ps

module mci_lite_decode #(
    parameter int unsigned SRAM_SIZE_KB = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    // SoC side
    input  mci_lite_pkg::soc_req_t soc_req,
    output mci_lite_pkg::soc_rsp_t soc_rsp,

    // Target side
    output mci_lite_pkg::soc_req_t regs_req,
    output mci_lite_pkg::soc_req_t trace_req,
    output mci_lite_pkg::soc_req_t sram_req,
    input  mci_lite_pkg::soc_rsp_t regs_rsp,
    input  mci_lite_pkg::soc_rsp_t trace_rsp,
    input  mci_lite_pkg::soc_rsp_t sram_rsp,

    // Privileged users from straps
    input  logic [31:0]            strap_mcu_lsu_user,
    input  logic [31:0]            strap_mcu_ifu_user,
    input  logic [31:0]            strap_soc_config_user,
    input  logic [31:0]            strap_sram_config_user,

    output mci_lite_pkg::priv_t    priv
);

    // Window ends, inclusive
    localparam logic [31:0] REGS_END_ADDR =
        mci_lite_pkg::REGS_START_ADDR + mci_lite_pkg::REGS_SIZE_BYTES - 32'd1;
    localparam logic [31:0] TRACE_END_ADDR =
        mci_lite_pkg::TRACE_START_ADDR + mci_lite_pkg::TRACE_SIZE_BYTES - 32'd1;
    localparam logic [31:0] SRAM_END_ADDR =
        mci_lite_pkg::SRAM_START_ADDR + 32'(SRAM_SIZE_KB * mci_lite_pkg::KB) - 32'd1;

    mci_lite_pkg::target_e  tgt;
    mci_lite_pkg::soc_rsp_t tgt_rsp;
    logic                   req_miss;
    logic                   lsu_match;
    logic                   ifu_match;
    logic                   soc_config_match;
    logic                   soc_config_disable;
    logic                   soc_config_force;

    //////////////////////////////////////////////////////////////////////
    // Address classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        tgt = mci_lite_pkg::TGT_NONE;
        if (soc_req.addr inside {[mci_lite_pkg::REGS_START_ADDR:REGS_END_ADDR]}) begin
            tgt = mci_lite_pkg::TGT_REGS;
        end else if (soc_req.addr inside {[mci_lite_pkg::TRACE_START_ADDR:TRACE_END_ADDR]}) begin
            tgt = mci_lite_pkg::TGT_TRACE;
        end else if (soc_req.addr inside {[mci_lite_pkg::SRAM_START_ADDR:SRAM_END_ADDR]}) begin
            tgt = mci_lite_pkg::TGT_SRAM;
        end
    end

    // Valid request that hits no window
    assign req_miss = soc_req.dv & (tgt == mci_lite_pkg::TGT_NONE);

    // Same payload to all, dv only toward the selected target
    always_comb begin
        regs_req     = soc_req;
        trace_req    = soc_req;
        sram_req     = soc_req;
        regs_req.dv  = soc_req.dv & (tgt == mci_lite_pkg::TGT_REGS);
        trace_req.dv = soc_req.dv & (tgt == mci_lite_pkg::TGT_TRACE);
        sram_req.dv  = soc_req.dv & (tgt == mci_lite_pkg::TGT_SRAM);
    end

    //////////////////////////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (tgt)
            mci_lite_pkg::TGT_REGS:  tgt_rsp = regs_rsp;
            mci_lite_pkg::TGT_TRACE: tgt_rsp = trace_rsp;
            mci_lite_pkg::TGT_SRAM:  tgt_rsp = sram_rsp;
            default:                 tgt_rsp = '0;
        endcase
    end

    // Idle bus returns all zeros; a miss ends at once with an error
    always_comb begin
        soc_rsp = '0;
        if (soc_req.dv) begin
            soc_rsp.rdata = tgt_rsp.rdata;
            soc_rsp.hold  = tgt_rsp.hold;
            soc_rsp.error = tgt_rsp.error | req_miss;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Privilege detection
    //////////////////////////////////////////////////////////////////////

    assign lsu_match        = (soc_req.user == strap_mcu_lsu_user);
    assign ifu_match        = (soc_req.user == strap_mcu_ifu_user);
    assign soc_config_match = (soc_req.user == strap_soc_config_user);

    // All zeros strap turns the SoC config user off
    assign soc_config_disable = ~|strap_soc_config_user;
    // All ones strap grants SoC config to every user
    assign soc_config_force   = &strap_soc_config_user;

    always_comb begin
        priv = '0;
        if (soc_req.dv) begin
            priv.mcu_lsu     = lsu_match;
            priv.mcu_ifu     = ifu_match;
            priv.mcu         = lsu_match | ifu_match;
            priv.soc_config  = (soc_config_match & ~soc_config_disable) | soc_config_force;
            priv.sram_config = (soc_req.user == strap_sram_config_user);
        end
    end

endmodule

//--- rtl/mci_lite_pkg.sv
// Shared types and address map of the MCI lite subsystem
// Address map assumes each window start is aligned to its size
// Register offsets are byte offsets inside the register window
// Requests and responses use the dv/hold/error handshake
package mci_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Request direction
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // Decoded destination of a request
    typedef enum logic [1:0] {
        TGT_NONE  = 2'd0,
        TGT_REGS  = 2'd1,
        TGT_TRACE = 2'd2,
        TGT_SRAM  = 2'd3
    } target_e;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned KB = 1024;

    localparam logic [31:0] REGS_START_ADDR  = 32'h0000_0000;
    localparam logic [31:0] REGS_SIZE_BYTES  = 32'h0000_0100;
    localparam logic [31:0] TRACE_START_ADDR = 32'h0001_0000;
    localparam logic [31:0] TRACE_SIZE_BYTES = 32'h0000_0400;
    // SRAM size comes from the top level parameter
    localparam logic [31:0] SRAM_START_ADDR  = 32'h00C0_0000;

    // Control register offsets
    localparam logic [7:0] REG_ID_OFFSET         = 8'h00;
    localparam logic [7:0] REG_SCRATCH_OFFSET    = 8'h04;
    localparam logic [7:0] REG_SOC_CONFIG_OFFSET = 8'h08;

    // Value returned by the ID register
    localparam logic [31:0] MCI_LITE_ID = 32'h4D43_4C31;

    //////////////////////////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        dv;
        op_e         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] user;
    } soc_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        hold;
        logic        error;
    } soc_rsp_t;

    // Privilege flags derived from the request user field
    typedef struct packed {
        logic mcu_lsu;
        logic mcu_ifu;
        logic mcu;
        logic soc_config;
        logic sram_config;
    } priv_t;

endpackage

//--- rtl/mci_lite_regs.sv
// Control register block: ID, SCRATCH and SOC_CONFIG
// Single cycle access, hold is never raised
// Only the low byte of the address is decoded
// SOC_CONFIG write needs the SoC config privilege
`timescale 1ns/100ps

module mci_lite_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  mci_lite_pkg::soc_req_t req,
    input  mci_lite_pkg::priv_t    priv,
    output mci_lite_pkg::soc_rsp_t rsp
);

    localparam int unsigned OFF_W = $clog2(mci_lite_pkg::REGS_SIZE_BYTES);

    logic [OFF_W-1:0] offset;
    logic             is_write;
    logic             sel_id;
    logic             sel_scratch;
    logic             sel_soc_config;
    logic             wr_scratch;
    logic             wr_soc_config;
    logic [31:0]      scratch_q;
    logic [31:0]      soc_config_q;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign offset         = req.addr[OFF_W-1:0];
    assign is_write       = (req.op == mci_lite_pkg::OP_WRITE);
    assign sel_id         = (offset == mci_lite_pkg::REG_ID_OFFSET);
    assign sel_scratch    = (offset == mci_lite_pkg::REG_SCRATCH_OFFSET);
    assign sel_soc_config = (offset == mci_lite_pkg::REG_SOC_CONFIG_OFFSET);

    // Write strobes, hold is always low so dv completes the transfer
    assign wr_scratch    = req.dv & is_write & sel_scratch;
    assign wr_soc_config = req.dv & is_write & sel_soc_config & priv.soc_config;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch_q    <= '0;
            soc_config_q <= '0;
        end else begin
            if (wr_scratch) begin
                scratch_q <= req.wdata;
            end
            if (wr_soc_config) begin
                soc_config_q <= req.wdata;
            end
        end
    end

    // Read data and error
    always_comb begin
        rsp = '0;
        if (req.dv) begin
            if (sel_id) begin
                rsp.rdata = mci_lite_pkg::MCI_LITE_ID;
                // ID is read only
                rsp.error = is_write;
            end else if (sel_scratch) begin
                rsp.rdata = scratch_q;
            end else if (sel_soc_config) begin
                rsp.rdata = soc_config_q;
                rsp.error = is_write & ~priv.soc_config;
            end else begin
                // Unused offset
                rsp.error = 1'b1;
            end
        end
    end

endmodule

//--- rtl/mci_lite_sram.sv
// MCU SRAM, word addressed, SRAM_SIZE_KB * 256 words
// Reads take one wait state; writes complete in the dv cycle
// Window start must be aligned to the SRAM size
// Writes need the MCU or SRAM config privilege
`timescale 1ns/100ps

module mci_lite_sram #(
    parameter int unsigned SRAM_SIZE_KB = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mci_lite_pkg::soc_req_t req,
    input  mci_lite_pkg::priv_t    priv,
    output mci_lite_pkg::soc_rsp_t rsp
);

    localparam int unsigned DEPTH = SRAM_SIZE_KB * (mci_lite_pkg::KB / 4);
    localparam int unsigned AW    = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] word_idx;
    logic          is_write;
    logic          wr_allowed;
    logic          wr_en;
    logic          rd_start;
    logic          rd_wait_q;
    logic [31:0]   rdata_q;

    assign word_idx   = req.addr[AW+1:2];
    assign is_write   = (req.op == mci_lite_pkg::OP_WRITE);
    assign wr_allowed = priv.mcu | priv.sram_config;
    assign wr_en      = req.dv & is_write & wr_allowed;

    // First cycle of a read, data not yet fetched
    assign rd_start = req.dv & ~is_write & ~rd_wait_q;

    //////////////////////////////////////////////////////////////////////
    // Wait state
    //////////////////////////////////////////////////////////////////////

    // Set on the held cycle, cleared on the completing one
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= rd_start;
        end
    end

    // Array and read register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= req.wdata;
        end
        if (rd_start) begin
            rdata_q <= mem[word_idx];
        end
    end

    always_comb begin
        rsp       = '0;
        rsp.rdata = rdata_q;
        rsp.hold  = rd_start;
        // Denied write leaves the array untouched
        rsp.error = req.dv & is_write & ~wr_allowed;
    end

endmodule

//--- rtl/mci_lite_top.sv
// MCI lite top level: decoder plus control registers, trace buffer, SRAM
// Straps must be held stable while requests are in flight
// priv output mirrors the flags seen by the targets
`timescale 1ns/100ps

module mci_lite_top #(
    parameter int unsigned SRAM_SIZE_KB = 4,
    parameter int unsigned TRACE_DEPTH  = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mci_lite_pkg::soc_req_t soc_req,
    output mci_lite_pkg::soc_rsp_t soc_rsp,
    input  logic [31:0]            strap_mcu_lsu_user,
    input  logic [31:0]            strap_mcu_ifu_user,
    input  logic [31:0]            strap_soc_config_user,
    input  logic [31:0]            strap_sram_config_user,
    output mci_lite_pkg::priv_t    priv
);

    mci_lite_pkg::soc_req_t regs_req;
    mci_lite_pkg::soc_req_t trace_req;
    mci_lite_pkg::soc_req_t sram_req;
    mci_lite_pkg::soc_rsp_t regs_rsp;
    mci_lite_pkg::soc_rsp_t trace_rsp;
    mci_lite_pkg::soc_rsp_t sram_rsp;

    //////////////////////////////////////////////////////////////////////
    // Decoder
    //////////////////////////////////////////////////////////////////////

    mci_lite_decode #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB)
    ) u_decode (
        .clk                   (clk),
        .reset                 (reset),
        .soc_req               (soc_req),
        .soc_rsp               (soc_rsp),
        .regs_req              (regs_req),
        .trace_req             (trace_req),
        .sram_req              (sram_req),
        .regs_rsp              (regs_rsp),
        .trace_rsp             (trace_rsp),
        .sram_rsp              (sram_rsp),
        .strap_mcu_lsu_user    (strap_mcu_lsu_user),
        .strap_mcu_ifu_user    (strap_mcu_ifu_user),
        .strap_soc_config_user (strap_soc_config_user),
        .strap_sram_config_user(strap_sram_config_user),
        .priv                  (priv)
    );

    // Targets, each checks its own write permission
    mci_lite_regs u_regs (
        .clk  (clk),
        .reset(reset),
        .req  (regs_req),
        .priv (priv),
        .rsp  (regs_rsp)
    );

    mci_lite_trace_buffer #(
        .TRACE_DEPTH(TRACE_DEPTH)
    ) u_trace (
        .clk  (clk),
        .reset(reset),
        .req  (trace_req),
        .priv (priv),
        .rsp  (trace_rsp)
    );

    mci_lite_sram #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB)
    ) u_sram (
        .clk  (clk),
        .reset(reset),
        .req  (sram_req),
        .priv (priv),
        .rsp  (sram_rsp)
    );

endmodule

//--- rtl/mci_lite_trace_buffer.sv
// Circular trace log written by MCU users through offset 0
// TRACE_DEPTH must be a power of two between 2 and 255
// Offset 0 reads the write pointer, offset 4*(1+i) reads entry i
// Entries are not cleared by reset, only the pointer is
`timescale 1ns/100ps

module mci_lite_trace_buffer #(
    parameter int unsigned TRACE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mci_lite_pkg::soc_req_t req,
    input  mci_lite_pkg::priv_t    priv,
    output mci_lite_pkg::soc_rsp_t rsp
);

    localparam int unsigned OFF_W = $clog2(mci_lite_pkg::TRACE_SIZE_BYTES);
    localparam int unsigned PTR_W = $clog2(TRACE_DEPTH);

    logic [31:0]      entries [TRACE_DEPTH];
    logic [OFF_W-1:0] offset;
    logic [OFF_W-3:0] word_num;
    logic [OFF_W-3:0] entry_num;
    logic [PTR_W-1:0] entry_idx;
    logic [PTR_W-1:0] wr_ptr_q;
    logic             is_write;
    logic             sel_ptr;
    logic             sel_entry;
    logic             wr_en;

    //////////////////////////////////////////////////////////////////////
    // Offset decode
    //////////////////////////////////////////////////////////////////////

    assign offset    = req.addr[OFF_W-1:0];
    assign word_num  = offset[OFF_W-1:2];
    assign entry_num = word_num - 1'b1;
    assign entry_idx = entry_num[PTR_W-1:0];
    assign is_write  = (req.op == mci_lite_pkg::OP_WRITE);
    assign sel_ptr   = (offset == '0);

    // Word aligned and inside 1..TRACE_DEPTH
    assign sel_entry = (offset[1:0] == 2'b00) && (word_num != '0) &&
                       (32'(word_num) <= TRACE_DEPTH);

    // Log write, only MCU users at offset 0
    assign wr_en = req.dv & is_write & sel_ptr & priv.mcu;

    //////////////////////////////////////////////////////////////////////
    // Pointer and log storage
    //////////////////////////////////////////////////////////////////////

    // Pointer wraps on its own width
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
        end else if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_ptr_q] <= req.wdata;
        end
    end

    always_comb begin
        rsp = '0;
        if (req.dv) begin
            if (is_write) begin
                rsp.error = ~(sel_ptr & priv.mcu);
            end else if (sel_ptr) begin
                rsp.rdata = 32'(wr_ptr_q);
            end else if (sel_entry) begin
                rsp.rdata = entries[entry_idx];
            end else begin
                rsp.error = 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the MCI lite testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mci_lite_tb -f build.f

# Keep running after a checker error so the testbench can report it
output=$(./obj_dir/Vmci_lite_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1

//--- sim/mci_lite_checker.sv
// Concurrent checks on the decoder routing and dv/hold handshake
// Bound into every mci_lite_decode instance
// All checks are off while reset is high
// Hold rules assume the requester keeps the request stable while held
`timescale 1ns/100ps

module mci_lite_checker (
    input logic                   clk,
    input logic                   reset,
    input mci_lite_pkg::soc_req_t soc_req,
    input mci_lite_pkg::soc_rsp_t soc_rsp,
    input mci_lite_pkg::soc_req_t regs_req,
    input mci_lite_pkg::soc_req_t trace_req,
    input mci_lite_pkg::soc_req_t sram_req
);

    // Number of failed checks so far
    int unsigned fail_count = 0;
    logic        req_miss;
    logic        sram_read;

    // Valid request that reached no target
    assign req_miss  = soc_req.dv & ~regs_req.dv & ~trace_req.dv & ~sram_req.dv;
    assign sram_read = sram_req.dv & (sram_req.op == mci_lite_pkg::OP_READ);

    //////////////////////////////////////////////////////////////////////
    // Routing
    //////////////////////////////////////////////////////////////////////

    one_target_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0({regs_req.dv, trace_req.dv, sram_req.dv}))
    else begin
        fail_count = fail_count + 1;
        $error("more than one target has dv set");
    end

    // Miss ends at once with error and zero data
    miss_error_a: assert property (@(posedge clk) disable iff (reset)
        req_miss |-> (soc_rsp.error && !soc_rsp.hold && soc_rsp.rdata == '0))
    else begin
        fail_count = fail_count + 1;
        $error("unmapped request did not return error with zero data");
    end

    //////////////////////////////////////////////////////////////////////
    // Back-pressure
    //////////////////////////////////////////////////////////////////////

    hold_source_a: assert property (@(posedge clk) disable iff (reset)
        soc_rsp.hold |-> sram_read)
    else begin
        fail_count = fail_count + 1;
        $error("hold raised outside an SRAM read");
    end

    // Held on the first cycle only, then completes
    hold_first_a: assert property (@(posedge clk) disable iff (reset)
        sram_read |-> (soc_rsp.hold == !$past(soc_rsp.hold)))
    else begin
        fail_count = fail_count + 1;
        $error("SRAM read hold not exactly one cycle");
    end

    idle_quiet_a: assert property (@(posedge clk) disable iff (reset)
        !soc_req.dv |-> (!soc_rsp.hold && !soc_rsp.error))
    else begin
        fail_count = fail_count + 1;
        $error("hold or error set while the bus is idle");
    end

endmodule

bind mci_lite_decode mci_lite_checker u_checker (
    .clk      (clk),
    .reset    (reset),
    .soc_req  (soc_req),
    .soc_rsp  (soc_rsp),
    .regs_req (regs_req),
    .trace_req(trace_req),
    .sram_req (sram_req)
);

//--- sim/mci_lite_tb.sv
// Testbench for mci_lite_top with SRAM_SIZE_KB 4 and TRACE_DEPTH 8
// Inputs change on the falling clock edge, outputs are sampled 1 ns later
// Reference model holds scratch, SOC_CONFIG, SRAM words and the trace log
// Straps change only while the bus is idle
`timescale 1ns/100ps

module mci_lite_tb;

    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned RESET_CYCLES = 3;
    localparam int unsigned SRAM_SIZE_KB = 4;
    localparam int unsigned TRACE_DEPTH  = 8;
    localparam int unsigned SRAM_WORDS   = SRAM_SIZE_KB * 256;
    localparam int unsigned MAX_HOLD     = 8;
    // Upper bound on transfers of at most four cycles each, margin of five
    localparam int unsigned XFER_LIMIT   = 125;
    localparam int unsigned WATCHDOG_NS  = 5 * (RESET_CYCLES + 4 * XFER_LIMIT) * CLK_PERIOD;

    // Strap users and one user that matches no strap
    localparam logic [31:0] LSU_USER      = 32'h0000_1001;
    localparam logic [31:0] IFU_USER      = 32'h0000_1002;
    localparam logic [31:0] SOC_CFG_USER  = 32'h0000_2003;
    localparam logic [31:0] SRAM_CFG_USER = 32'h0000_3004;
    localparam logic [31:0] FOREIGN_USER  = 32'h0000_7777;

    localparam logic [31:0] REG_ID      = {24'd0, mci_lite_pkg::REG_ID_OFFSET};
    localparam logic [31:0] REG_SCRATCH = {24'd0, mci_lite_pkg::REG_SCRATCH_OFFSET};
    localparam logic [31:0] REG_SOC_CFG = {24'd0, mci_lite_pkg::REG_SOC_CONFIG_OFFSET};
    localparam logic [31:0] TRACE_BASE  = mci_lite_pkg::TRACE_START_ADDR;

    logic                   clk = 1'b0;
    logic                   reset;
    mci_lite_pkg::soc_req_t soc_req;
    mci_lite_pkg::soc_rsp_t soc_rsp;
    mci_lite_pkg::priv_t    priv;
    logic [31:0]            strap_lsu;
    logic [31:0]            strap_ifu;
    logic [31:0]            strap_soc_cfg;
    logic [31:0]            strap_sram_cfg;

    // Reference model
    logic [31:0] scratch_ref;
    logic [31:0] soc_config_ref;
    logic [31:0] sram_ref [SRAM_WORDS];
    logic [31:0] trace_ref [TRACE_DEPTH];
    int unsigned trace_ptr_ref;
    logic [31:0] rng_state = 32'ha3c6_f68e;

    mci_lite_top #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB),
        .TRACE_DEPTH (TRACE_DEPTH)
    ) uut (
        .clk                   (clk),
        .reset                 (reset),
        .soc_req               (soc_req),
        .soc_rsp               (soc_rsp),
        .strap_mcu_lsu_user    (strap_lsu),
        .strap_mcu_ifu_user    (strap_ifu),
        .strap_soc_config_user (strap_soc_cfg),
        .strap_sram_config_user(strap_sram_cfg),
        .priv                  (priv)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_now($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    // LCG, numerical recipes constants
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Privilege rules applied to the current straps
    function automatic mci_lite_pkg::priv_t expected_priv(input logic [31:0] user);
        mci_lite_pkg::priv_t p;
        p         = '0;
        p.mcu_lsu = (user == strap_lsu);
        p.mcu_ifu = (user == strap_ifu);
        p.mcu     = p.mcu_lsu | p.mcu_ifu;
        if (strap_soc_cfg == 32'h0) begin
            p.soc_config = 1'b0;
        end else if (strap_soc_cfg == 32'hFFFF_FFFF) begin
            p.soc_config = 1'b1;
        end else begin
            p.soc_config = (user == strap_soc_cfg);
        end
        p.sram_config = (user == strap_sram_cfg);
        return p;
    endfunction

    function automatic logic [31:0] sram_addr(input int unsigned idx);
        return mci_lite_pkg::SRAM_START_ADDR + (idx << 2);
    endfunction

    // One transfer, waits out hold, then leaves the bus idle
    task automatic do_xfer(input mci_lite_pkg::op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] user,
                           output mci_lite_pkg::soc_rsp_t rsp, output int unsigned holds);
        mci_lite_pkg::priv_t exp_priv;
        @(negedge clk);
        soc_req.dv    = 1'b1;
        soc_req.op    = op;
        soc_req.addr  = addr;
        soc_req.wdata = wdata;
        soc_req.user  = user;
        holds         = 0;
        #1;
        exp_priv = expected_priv(user);
        check_value("priv", {27'd0, priv}, {27'd0, exp_priv});
        while (soc_rsp.hold) begin
            holds++;
            if (holds > MAX_HOLD) begin
                fail_now($sformatf("hold never dropped for address %h", addr));
            end
            @(negedge clk);
            #1;
        end
        rsp = soc_rsp;
        @(negedge clk);
        soc_req.dv = 1'b0;
        #1;
        // Idle bus, everything quiet
        check_value("idle soc_rsp.hold", {31'd0, soc_rsp.hold}, 32'd0);
        check_value("idle soc_rsp.error", {31'd0, soc_rsp.error}, 32'd0);
        check_value("idle priv", {27'd0, priv}, 32'd0);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] user, input logic exp_err);
        mci_lite_pkg::soc_rsp_t rsp;
        int unsigned            holds;
        do_xfer(mci_lite_pkg::OP_WRITE, addr, data, user, rsp, holds);
        check_value("soc_rsp.error", {31'd0, rsp.error}, {31'd0, exp_err});
        check_value("write hold cycles", holds, 32'd0);
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [31:0] user,
                             input logic [31:0] exp_data, input logic exp_err,
                             input int unsigned exp_holds);
        mci_lite_pkg::soc_rsp_t rsp;
        int unsigned            holds;
        do_xfer(mci_lite_pkg::OP_READ, addr, 32'h0, user, rsp, holds);
        check_value("soc_rsp.error", {31'd0, rsp.error}, {31'd0, exp_err});
        check_value("read hold cycles", holds, exp_holds);
        if (!exp_err) begin
            check_value("soc_rsp.rdata", rsp.rdata, exp_data);
        end
    endtask

    // Unmapped address, error and zero data in the same cycle
    task automatic check_miss(input mci_lite_pkg::op_e op, input logic [31:0] addr);
        mci_lite_pkg::soc_rsp_t rsp;
        int unsigned            holds;
        do_xfer(op, addr, next_random(), FOREIGN_USER, rsp, holds);
        check_value("miss soc_rsp.error", {31'd0, rsp.error}, 32'd1);
        check_value("miss soc_rsp.rdata", rsp.rdata, 32'd0);
        check_value("miss hold cycles", holds, 32'd0);
    endtask

    task automatic soc_config_write(input logic [31:0] data, input logic [31:0] user);
        mci_lite_pkg::priv_t p;
        p = expected_priv(user);
        write_word(REG_SOC_CFG, data, user, ~p.soc_config);
        if (p.soc_config) begin
            soc_config_ref = data;
        end
    endtask

    task automatic sram_write(input int unsigned idx, input logic [31:0] data,
                              input logic [31:0] user);
        mci_lite_pkg::priv_t p;
        logic                allowed;
        p       = expected_priv(user);
        allowed = p.mcu | p.sram_config;
        write_word(sram_addr(idx), data, user, ~allowed);
        if (allowed) begin
            sram_ref[idx] = data;
        end
    endtask

    task automatic trace_write(input logic [31:0] data, input logic [31:0] user);
        mci_lite_pkg::priv_t p;
        p = expected_priv(user);
        write_word(TRACE_BASE, data, user, ~p.mcu);
        if (p.mcu) begin
            trace_ref[trace_ptr_ref] = data;
            trace_ptr_ref = (trace_ptr_ref + 1) % TRACE_DEPTH;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    // Failed checker assertions end the run here
    always @(negedge clk) begin
        if (uut.u_decode.u_checker.fail_count != 0) begin
            fail_now("a decoder checker assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] data;
        int unsigned idx [8];
        logic [31:0] users [5];
        soc_req        = '0;
        reset          = 1'b1;
        strap_lsu      = LSU_USER;
        strap_ifu      = IFU_USER;
        strap_soc_cfg  = SOC_CFG_USER;
        strap_sram_cfg = SRAM_CFG_USER;
        scratch_ref    = 32'h0;
        soc_config_ref = 32'h0;
        trace_ptr_ref  = 0;
        users          = '{LSU_USER, IFU_USER, SOC_CFG_USER, SRAM_CFG_USER, FOREIGN_USER};
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Scratch round trip, ID value, ID is read only
        data = next_random();
        write_word(REG_SCRATCH, data, FOREIGN_USER, 1'b0);
        scratch_ref = data;
        read_word(REG_SCRATCH, FOREIGN_USER, scratch_ref, 1'b0, 0);
        read_word(REG_ID, FOREIGN_USER, mci_lite_pkg::MCI_LITE_ID, 1'b0, 0);
        write_word(REG_ID, next_random(), LSU_USER, 1'b1);

        // SOC_CONFIG privilege, normal, disabled and forced strap
        soc_config_write(next_random(), SOC_CFG_USER);
        soc_config_write(next_random(), FOREIGN_USER);
        read_word(REG_SOC_CFG, FOREIGN_USER, soc_config_ref, 1'b0, 0);
        @(negedge clk);
        strap_soc_cfg = 32'h0;
        soc_config_write(next_random(), 32'h0);
        read_word(REG_SOC_CFG, FOREIGN_USER, soc_config_ref, 1'b0, 0);
        @(negedge clk);
        strap_soc_cfg = 32'hFFFF_FFFF;
        soc_config_write(next_random(), FOREIGN_USER);
        read_word(REG_SOC_CFG, FOREIGN_USER, soc_config_ref, 1'b0, 0);
        @(negedge clk);
        strap_soc_cfg = SOC_CFG_USER;

        // Unmapped windows and an unused register offset
        check_miss(mci_lite_pkg::OP_READ, 32'h0000_0100);
        check_miss(mci_lite_pkg::OP_WRITE, 32'h0001_0400);
        check_miss(mci_lite_pkg::OP_READ, sram_addr(SRAM_WORDS));
        check_miss(mci_lite_pkg::OP_READ, 32'hFFFF_FFFC);
        read_word(32'h0000_000C, FOREIGN_USER, 32'h0, 1'b1, 0);

        // SRAM, random words by the LSU user, one wait state per read
        for (int i = 0; i < 8; i++) begin
            idx[i] = next_random() % SRAM_WORDS;
            sram_write(idx[i], next_random(), LSU_USER);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(sram_addr(idx[i]), LSU_USER, sram_ref[idx[i]], 1'b0, 1);
        end
        sram_write(idx[0], next_random(), FOREIGN_USER);
        read_word(sram_addr(idx[0]), FOREIGN_USER, sram_ref[idx[0]], 1'b0, 1);
        sram_write(idx[1], next_random(), SRAM_CFG_USER);
        read_word(sram_addr(idx[1]), LSU_USER, sram_ref[idx[1]], 1'b0, 1);

        // Trace log, ten writes wrap the pointer past the depth
        for (int i = 0; i < 10; i++) begin
            trace_write(next_random(), IFU_USER);
        end
        read_word(TRACE_BASE, FOREIGN_USER, trace_ptr_ref, 1'b0, 0);
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            read_word(TRACE_BASE + 4 * (1 + i), FOREIGN_USER, trace_ref[i], 1'b0, 0);
        end
        trace_write(next_random(), SOC_CFG_USER);
        read_word(TRACE_BASE, FOREIGN_USER, trace_ptr_ref, 1'b0, 0);
        read_word(TRACE_BASE + 4 * (1 + TRACE_DEPTH), FOREIGN_USER, 32'h0, 1'b1, 0);

        // Privilege flags for every strap user and a foreign one
        foreach (users[i]) begin
            read_word(REG_SCRATCH, users[i], scratch_ref, 1'b0, 0);
        end

        if (uut.u_decode.u_checker.fail_count != 0) begin
            fail_now("decoder checker reported failed assertions");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
